//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := mem_subsys_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only if the pass line shows up in the simulator output
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "ALL TESTS PASSED"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire                      clk,
  input  wire                      rst,
  // client 1 read channel
  input  wire                      arvalid1,
  input  wire mem_bus_pkg::addr_t  araddr1,
  input  wire                      rready1,
  output logic                     arready1,
  output logic                     rvalid1,
  output mem_bus_pkg::resp_t       rresp1,
  output mem_bus_pkg::data_t       rdata1,
  // client 2 read channel
  input  wire                      arvalid2,
  input  wire mem_bus_pkg::addr_t  araddr2,
  input  wire                      rready2,
  output logic                     arready2,
  output logic                     rvalid2,
  output mem_bus_pkg::resp_t       rresp2,
  output mem_bus_pkg::data_t       rdata2,
  // client 2 write channel
  input  wire                      awvalid2,
  input  wire mem_bus_pkg::addr_t  awaddr2,
  input  wire                      wvalid2,
  input  wire mem_bus_pkg::data_t  wdata2,
  input  wire mem_bus_pkg::strb_t  wstrb2,
  input  wire                      bready2,
  output logic                     awready2,
  output logic                     wready2,
  output logic                     bvalid2,
  output mem_bus_pkg::resp_t       bresp2,
  // toward the sram slave
  output logic                     arvalid,
  output mem_bus_pkg::addr_t       araddr,
  output logic                     rready,
  output logic                     awvalid,
  output mem_bus_pkg::addr_t       awaddr,
  output logic                     wvalid,
  output mem_bus_pkg::data_t       wdata,
  output mem_bus_pkg::strb_t       wstrb,
  output logic                     bready,
  input  wire                      arready,
  input  wire                      rvalid,
  input  wire mem_bus_pkg::resp_t  rresp,
  input  wire mem_bus_pkg::data_t  rdata,
  input  wire                      awready,
  input  wire                      wready,
  input  wire                      bvalid,
  input  wire mem_bus_pkg::resp_t  bresp
);

  mem_bus_pkg::arb_read_state_t  rd_state;
  mem_bus_pkg::arb_write_state_t wr_state;

  logic grant1;
  logic grant2;
  logic wr_grant;

  assign grant1   = (rd_state == mem_bus_pkg::READ_CLIENT1);
  assign grant2   = (rd_state == mem_bus_pkg::READ_CLIENT2);
  assign wr_grant = (wr_state == mem_bus_pkg::WRITE_CLIENT2);

  // fixed priority, client 1 first
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= mem_bus_pkg::READ_IDLE;
    end else begin
      case (rd_state)
        mem_bus_pkg::READ_IDLE: begin
          if (arvalid1) begin
            rd_state <= mem_bus_pkg::READ_CLIENT1;
          end else if (arvalid2) begin
            rd_state <= mem_bus_pkg::READ_CLIENT2;
          end
        end
        mem_bus_pkg::READ_CLIENT1,
        mem_bus_pkg::READ_CLIENT2: begin
          // release only once the data beat has transferred
          if (rvalid && rready) begin
            rd_state <= mem_bus_pkg::READ_IDLE;
          end
        end
        default: begin
          rd_state <= mem_bus_pkg::READ_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= mem_bus_pkg::WRITE_IDLE;
    end else begin
      case (wr_state)
        mem_bus_pkg::WRITE_IDLE: begin
          if (awvalid2 && wvalid2) begin
            wr_state <= mem_bus_pkg::WRITE_CLIENT2;
          end
        end
        mem_bus_pkg::WRITE_CLIENT2: begin
          if (bvalid && bready) begin
            wr_state <= mem_bus_pkg::WRITE_IDLE;
          end
        end
        default: begin
          wr_state <= mem_bus_pkg::WRITE_IDLE;
        end
      endcase
    end
  end

  // read request path to the slave
  always_comb begin
    case (rd_state)
      mem_bus_pkg::READ_CLIENT1: begin
        arvalid = arvalid1;
        araddr  = araddr1;
        rready  = rready1;
      end
      mem_bus_pkg::READ_CLIENT2: begin
        arvalid = arvalid2;
        araddr  = araddr2;
        rready  = rready2;
      end
      default: begin
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
      end
    endcase
  end

  // read response path, zeros to whoever is not granted
  assign arready1 = grant1 ? arready : 1'b0;
  assign rvalid1  = grant1 ? rvalid  : 1'b0;
  assign rresp1   = grant1 ? rresp   : '0;
  assign rdata1   = grant1 ? rdata   : '0;

  assign arready2 = grant2 ? arready : 1'b0;
  assign rvalid2  = grant2 ? rvalid  : 1'b0;
  assign rresp2   = grant2 ? rresp   : '0;
  assign rdata2   = grant2 ? rdata   : '0;

  // write gate for client 2
  assign awvalid = wr_grant ? awvalid2 : 1'b0;
  assign awaddr  = wr_grant ? awaddr2  : '0;
  assign wvalid  = wr_grant ? wvalid2  : 1'b0;
  assign wdata   = wr_grant ? wdata2   : '0;
  assign wstrb   = wr_grant ? wstrb2   : '0;
  assign bready  = wr_grant ? bready2  : 1'b0;

  assign awready2 = wr_grant ? awready : 1'b0;
  assign wready2  = wr_grant ? wready  : 1'b0;
  assign bvalid2  = wr_grant ? bvalid  : 1'b0;
  assign bresp2   = wr_grant ? bresp   : '0;

endmodule

`default_nettype wire

//--- src/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  // 4 KiB sram window
  localparam addr_t SRAM_BASE  = 32'h8000_0000;
  localparam int    SRAM_WORDS = 1024;
  localparam int    SRAM_IDX_W = $clog2(SRAM_WORDS);
  typedef logic [SRAM_IDX_W-1:0] sram_idx_t;

  // cycles from read address accept to first rvalid cycle
  localparam int READ_LATENCY = 2;
  typedef logic [1:0] lat_cnt_t;

  typedef enum logic [1:0] {
    READ_IDLE,
    READ_CLIENT1,
    READ_CLIENT2
  } arb_read_state_t;

  typedef enum logic {
    WRITE_IDLE,
    WRITE_CLIENT2
  } arb_write_state_t;

  typedef enum logic [1:0] {
    SRAM_IDLE,
    SRAM_READ_WAIT,
    SRAM_READ_RESP,
    SRAM_WRITE_RESP
  } sram_state_t;

endpackage

`default_nettype wire

//--- src/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
  input  wire                      clk,
  input  wire                      rst,
  // instruction fetch, read only
  input  wire                      arvalid1,
  input  wire mem_bus_pkg::addr_t  araddr1,
  input  wire                      rready1,
  output logic                     arready1,
  output logic                     rvalid1,
  output mem_bus_pkg::resp_t       rresp1,
  output mem_bus_pkg::data_t       rdata1,
  // load/store read
  input  wire                      arvalid2,
  input  wire mem_bus_pkg::addr_t  araddr2,
  input  wire                      rready2,
  output logic                     arready2,
  output logic                     rvalid2,
  output mem_bus_pkg::resp_t       rresp2,
  output mem_bus_pkg::data_t       rdata2,
  // load/store write
  input  wire                      awvalid2,
  input  wire mem_bus_pkg::addr_t  awaddr2,
  input  wire                      wvalid2,
  input  wire mem_bus_pkg::data_t  wdata2,
  input  wire mem_bus_pkg::strb_t  wstrb2,
  input  wire                      bready2,
  output logic                     awready2,
  output logic                     wready2,
  output logic                     bvalid2,
  output mem_bus_pkg::resp_t       bresp2
);

  logic               arvalid;
  mem_bus_pkg::addr_t araddr;
  logic               rready;
  logic               awvalid;
  mem_bus_pkg::addr_t awaddr;
  logic               wvalid;
  mem_bus_pkg::data_t wdata;
  mem_bus_pkg::strb_t wstrb;
  logic               bready;
  logic               arready;
  logic               rvalid;
  mem_bus_pkg::resp_t rresp;
  mem_bus_pkg::data_t rdata;
  logic               awready;
  logic               wready;
  logic               bvalid;
  mem_bus_pkg::resp_t bresp;

  mem_arbiter u_arbiter (
    .clk      (clk),
    .rst      (rst),
    .arvalid1 (arvalid1),
    .araddr1  (araddr1),
    .rready1  (rready1),
    .arready1 (arready1),
    .rvalid1  (rvalid1),
    .rresp1   (rresp1),
    .rdata1   (rdata1),
    .arvalid2 (arvalid2),
    .araddr2  (araddr2),
    .rready2  (rready2),
    .arready2 (arready2),
    .rvalid2  (rvalid2),
    .rresp2   (rresp2),
    .rdata2   (rdata2),
    .awvalid2 (awvalid2),
    .awaddr2  (awaddr2),
    .wvalid2  (wvalid2),
    .wdata2   (wdata2),
    .wstrb2   (wstrb2),
    .bready2  (bready2),
    .awready2 (awready2),
    .wready2  (wready2),
    .bvalid2  (bvalid2),
    .bresp2   (bresp2),
    .arvalid  (arvalid),
    .araddr   (araddr),
    .rready   (rready),
    .awvalid  (awvalid),
    .awaddr   (awaddr),
    .wvalid   (wvalid),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .bready   (bready),
    .arready  (arready),
    .rvalid   (rvalid),
    .rresp    (rresp),
    .rdata    (rdata),
    .awready  (awready),
    .wready   (wready),
    .bvalid   (bvalid),
    .bresp    (bresp)
  );

  sram_axi_slave u_sram (
    .clk     (clk),
    .rst     (rst),
    .arvalid (arvalid),
    .araddr  (araddr),
    .rready  (rready),
    .awvalid (awvalid),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .bready  (bready),
    .arready (arready),
    .rvalid  (rvalid),
    .rresp   (rresp),
    .rdata   (rdata),
    .awready (awready),
    .wready  (wready),
    .bvalid  (bvalid),
    .bresp   (bresp)
  );

endmodule

`default_nettype wire

//--- src/sram_axi_slave.sv
`timescale 1ns/1ps
`default_nettype none

module sram_axi_slave (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      arvalid,
  input  wire mem_bus_pkg::addr_t  araddr,
  input  wire                      rready,
  input  wire                      awvalid,
  input  wire mem_bus_pkg::addr_t  awaddr,
  input  wire                      wvalid,
  input  wire mem_bus_pkg::data_t  wdata,
  input  wire mem_bus_pkg::strb_t  wstrb,
  input  wire                      bready,
  output logic                     arready,
  output logic                     rvalid,
  output mem_bus_pkg::resp_t       rresp,
  output mem_bus_pkg::data_t       rdata,
  output logic                     awready,
  output logic                     wready,
  output logic                     bvalid,
  output mem_bus_pkg::resp_t       bresp
);

  mem_bus_pkg::sram_state_t state;
  mem_bus_pkg::lat_cnt_t    lat_cnt;

  mem_bus_pkg::data_t mem [mem_bus_pkg::SRAM_WORDS];

  mem_bus_pkg::sram_idx_t rd_idx;
  mem_bus_pkg::sram_idx_t wr_idx;
  logic                   rd_hit;
  logic                   ar_fire;
  logic                   aw_fire;
  logic                   ar_in_win;
  logic                   aw_in_win;

  // upper address bits must match the base
  function automatic logic in_window(input mem_bus_pkg::addr_t addr);
    return addr[31:mem_bus_pkg::SRAM_IDX_W+2] ==
           mem_bus_pkg::SRAM_BASE[31:mem_bus_pkg::SRAM_IDX_W+2];
  endfunction

  assign ar_in_win = in_window(araddr);
  assign aw_in_win = in_window(awaddr);
  assign wr_idx    = awaddr[mem_bus_pkg::SRAM_IDX_W+1:2];

  assign arready = (state == mem_bus_pkg::SRAM_IDLE);
  // read wins a same-cycle tie
  assign awready = (state == mem_bus_pkg::SRAM_IDLE) && awvalid && wvalid && !arvalid;
  assign wready  = awready;
  assign rvalid  = (state == mem_bus_pkg::SRAM_READ_RESP);
  assign bvalid  = (state == mem_bus_pkg::SRAM_WRITE_RESP);

  assign ar_fire = arvalid && arready;
  assign aw_fire = awvalid && awready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= mem_bus_pkg::SRAM_IDLE;
      lat_cnt <= '0;
    end else begin
      case (state)
        mem_bus_pkg::SRAM_IDLE: begin
          lat_cnt <= '0;
          if (ar_fire) begin
            // the accepting edge counts as the first latency cycle
            state   <= mem_bus_pkg::SRAM_READ_WAIT;
            lat_cnt <= mem_bus_pkg::lat_cnt_t'(1);
          end else if (aw_fire) begin
            state <= mem_bus_pkg::SRAM_WRITE_RESP;
          end
        end
        mem_bus_pkg::SRAM_READ_WAIT: begin
          if (lat_cnt == mem_bus_pkg::lat_cnt_t'(mem_bus_pkg::READ_LATENCY - 1)) begin
            state <= mem_bus_pkg::SRAM_READ_RESP;
          end else begin
            lat_cnt <= lat_cnt + 1'b1;
          end
        end
        mem_bus_pkg::SRAM_READ_RESP: begin
          if (rready) begin
            state <= mem_bus_pkg::SRAM_IDLE;
          end
        end
        mem_bus_pkg::SRAM_WRITE_RESP: begin
          if (bready) begin
            state <= mem_bus_pkg::SRAM_IDLE;
          end
        end
        default: begin
          state <= mem_bus_pkg::SRAM_IDLE;
        end
      endcase
    end
  end

  // read address capture and response data
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rd_idx <= araddr[mem_bus_pkg::SRAM_IDX_W+1:2];
      rd_hit <= ar_in_win;
    end
    if (state == mem_bus_pkg::SRAM_READ_WAIT &&
        lat_cnt == mem_bus_pkg::lat_cnt_t'(mem_bus_pkg::READ_LATENCY - 1)) begin
      rdata <= rd_hit ? mem[rd_idx] : '0;
      rresp <= rd_hit ? mem_bus_pkg::RESP_OKAY : mem_bus_pkg::RESP_SLVERR;
    end
  end

  // byte-strobed write
  // out-of-window writes leave the memory alone
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      bresp <= aw_in_win ? mem_bus_pkg::RESP_OKAY : mem_bus_pkg::RESP_SLVERR;
      if (aw_in_win) begin
        for (int b = 0; b < $bits(mem_bus_pkg::strb_t); b++) begin
          if (wstrb[b]) begin
            mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/mem_arbiter_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter_checker (
  input wire                               clk,
  input wire                               rst,
  input wire mem_bus_pkg::arb_read_state_t rd_state,
  input wire                               arready1,
  input wire                               rvalid1,
  input wire mem_bus_pkg::resp_t           rresp1,
  input wire mem_bus_pkg::data_t           rdata1,
  input wire                               arready2,
  input wire                               rvalid2,
  input wire mem_bus_pkg::resp_t           rresp2,
  input wire mem_bus_pkg::data_t           rdata2,
  input wire                               rvalid,
  input wire                               rready
);

  one_client_a: assert property (@(posedge clk) disable iff (rst)
    !((arready1 || rvalid1) && (arready2 || rvalid2)))
    else $error("both read clients see slave activity");

  // no grant, no traffic
  idle1_zero_a: assert property (@(posedge clk) disable iff (rst)
    (rd_state != mem_bus_pkg::READ_CLIENT1) |->
      (!arready1 && !rvalid1 && rresp1 == '0 && rdata1 == '0))
    else $error("client 1 outputs not zero without grant");

  idle2_zero_a: assert property (@(posedge clk) disable iff (rst)
    (rd_state != mem_bus_pkg::READ_CLIENT2) |->
      (!arready2 && !rvalid2 && rresp2 == '0 && rdata2 == '0))
    else $error("client 2 outputs not zero without grant");

  grant_hold_a: assert property (@(posedge clk) disable iff (rst)
    (rvalid && !rready) |=> $stable(rd_state))
    else $error("read grant moved while rvalid was pending");

endmodule

bind mem_arbiter mem_arbiter_checker u_checker (
  .clk      (clk),
  .rst      (rst),
  .rd_state (rd_state),
  .arready1 (arready1),
  .rvalid1  (rvalid1),
  .rresp1   (rresp1),
  .rdata1   (rdata1),
  .arready2 (arready2),
  .rvalid2  (rvalid2),
  .rresp2   (rresp2),
  .rdata2   (rdata2),
  .rvalid   (rvalid),
  .rready   (rready)
);

`default_nettype wire

//--- tests/mem_subsys_stim.txt
# op addr data strb, all hex; R1/R2 read, W2 writes data under the byte strobe
# P reads addr on client 1 and the data column as an address on client 2
W2 80000000 11223344 f
R2 80000000 00000000 0
W2 80000000 aabbccdd 5
R2 80000000 00000000 0
R1 80000000 00000000 0
W2 80000ffc deadbeef f
R1 80000ffc 00000000 0
W2 80000010 cafef00d f
W2 80000014 01020304 f
R2 80000014 00000000 0
P  80000010 80000014 0
W2 80000004 0000abcd 3
W2 80000004 12340000 c
R2 80000004 00000000 0
P  80000ffc 80000004 0
W2 80001000 ffffffff f
R2 80000000 00000000 0
W2 7ffffffc 87654321 f
R1 80000ffc 00000000 0
R2 80001000 00000000 0
R1 00000000 00000000 0
R2 7ffff000 00000000 0
W2 80000008 0badf00d f
W2 80000008 55aa55aa 0
R1 80000008 00000000 0
W2 80000008 55aa55aa 2
R2 80000008 00000000 0
P  80000008 80000010 0
P  80001000 80000008 0
W2 80000010 00ff00ff 9
P  80000010 80000000 0
R2 80000ffc 00000000 0
R1 80000004 00000000 0

//--- tests/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

  localparam int TIMEOUT_CYCLES = 200;

  typedef enum {SIG_ARREADY, SIG_RVALID, SIG_AWREADY, SIG_BVALID} sig_kind_t;

  logic               clk;
  logic               rst;
  logic               arvalid1;
  mem_bus_pkg::addr_t araddr1;
  logic               rready1;
  logic               arready1;
  logic               rvalid1;
  mem_bus_pkg::resp_t rresp1;
  mem_bus_pkg::data_t rdata1;
  logic               arvalid2;
  mem_bus_pkg::addr_t araddr2;
  logic               rready2;
  logic               arready2;
  logic               rvalid2;
  mem_bus_pkg::resp_t rresp2;
  mem_bus_pkg::data_t rdata2;
  logic               awvalid2;
  mem_bus_pkg::addr_t awaddr2;
  logic               wvalid2;
  mem_bus_pkg::data_t wdata2;
  mem_bus_pkg::strb_t wstrb2;
  logic               bready2;
  logic               awready2;
  logic               wready2;
  logic               bvalid2;
  mem_bus_pkg::resp_t bresp2;

  // reference copy of the sram contents
  mem_bus_pkg::data_t shadow [mem_bus_pkg::SRAM_WORDS];
  logic [31:0]        seed = 32'h63e3;
  int                 checks;
  int                 errors;
  int                 timeouts;

  mem_subsys_top u_dut (
    .clk      (clk),
    .rst      (rst),
    .arvalid1 (arvalid1),
    .araddr1  (araddr1),
    .rready1  (rready1),
    .arready1 (arready1),
    .rvalid1  (rvalid1),
    .rresp1   (rresp1),
    .rdata1   (rdata1),
    .arvalid2 (arvalid2),
    .araddr2  (araddr2),
    .rready2  (rready2),
    .arready2 (arready2),
    .rvalid2  (rvalid2),
    .rresp2   (rresp2),
    .rdata2   (rdata2),
    .awvalid2 (awvalid2),
    .awaddr2  (awaddr2),
    .wvalid2  (wvalid2),
    .wdata2   (wdata2),
    .wstrb2   (wstrb2),
    .bready2  (bready2),
    .awready2 (awready2),
    .wready2  (wready2),
    .bvalid2  (bvalid2),
    .bresp2   (bresp2)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // back-pressure of 0 to 3 cycles
  function automatic int random_delay();
    logic [31:0] r;
    r = lcg_next();
    return int'(r[17:16]);
  endfunction

  function automatic logic in_window(input mem_bus_pkg::addr_t a);
    return (a - mem_bus_pkg::SRAM_BASE) < 32'(mem_bus_pkg::SRAM_WORDS * 4);
  endfunction

  function automatic logic sig_value(input sig_kind_t kind, input int c);
    case (kind)
      SIG_ARREADY: return (c == 1) ? arready1 : arready2;
      SIG_RVALID:  return (c == 1) ? rvalid1 : rvalid2;
      SIG_AWREADY: return awready2;
      default:     return bvalid2;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  // called just after a falling edge, returns 1 ns after one
  task automatic wait_high(input sig_kind_t kind, input int c, input string name);
    int cycles;
    cycles = 0;
    #1;
    while (!sig_value(kind, c) && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      #1;
      cycles++;
    end
    if (!sig_value(kind, c)) begin
      timeouts++;
      $display("timeout at %0t ns: %s stayed low for %0d cycles", $time, name, TIMEOUT_CYCLES);
    end
  endtask

  task automatic drive_ar(input int c, input logic v, input mem_bus_pkg::addr_t a);
    if (c == 1) begin
      arvalid1 = v;
      araddr1  = a;
    end else begin
      arvalid2 = v;
      araddr2  = a;
    end
  endtask

  task automatic drive_rready(input int c, input logic v);
    if (c == 1) begin
      rready1 = v;
    end else begin
      rready2 = v;
    end
  endtask

  task automatic check_read(input int c, input string tag, input mem_bus_pkg::data_t exp_data,
                            input mem_bus_pkg::resp_t exp_resp);
    check_value({"rvalid", tag}, 32'(sig_value(SIG_RVALID, c)), 32'd1);
    check_value({"rdata", tag}, (c == 1) ? rdata1 : rdata2, exp_data);
    check_value({"rresp", tag}, 32'((c == 1) ? rresp1 : rresp2), 32'(exp_resp));
  endtask

  task automatic do_read(input int c, input mem_bus_pkg::addr_t a, input int dly,
                         output time t_rv, output time t_hs);
    mem_bus_pkg::data_t exp_data;
    mem_bus_pkg::resp_t exp_resp;
    string              tag;
    tag      = $sformatf("%0d", c);
    exp_data = in_window(a) ? shadow[a[11:2]] : '0;
    exp_resp = in_window(a) ? mem_bus_pkg::RESP_OKAY : mem_bus_pkg::RESP_SLVERR;
    @(negedge clk);
    drive_ar(c, 1'b1, a);
    wait_high(SIG_ARREADY, c, {"arready", tag});
    @(negedge clk);
    drive_ar(c, 1'b0, '0);
    wait_high(SIG_RVALID, c, {"rvalid", tag});
    t_rv = $time;
    check_read(c, tag, exp_data, exp_resp);
    // response must hold while rready is low
    repeat (dly) begin
      @(negedge clk);
      #1;
      check_read(c, tag, exp_data, exp_resp);
    end
    @(negedge clk);
    drive_rready(c, 1'b1);
    #1;
    check_read(c, tag, exp_data, exp_resp);
    t_hs = $time;
    @(negedge clk);
    drive_rready(c, 1'b0);
  endtask

  task automatic do_write(input mem_bus_pkg::addr_t a, input mem_bus_pkg::data_t d,
                          input mem_bus_pkg::strb_t s, input int dly);
    mem_bus_pkg::resp_t exp_resp;
    exp_resp = in_window(a) ? mem_bus_pkg::RESP_OKAY : mem_bus_pkg::RESP_SLVERR;
    @(negedge clk);
    awvalid2 = 1'b1;
    awaddr2  = a;
    wvalid2  = 1'b1;
    wdata2   = d;
    wstrb2   = s;
    wait_high(SIG_AWREADY, 2, "awready2");
    check_value("wready2", 32'(wready2), 32'd1);
    if (in_window(a)) begin
      for (int b = 0; b < 4; b++) begin
        if (s[b]) begin
          shadow[a[11:2]][8*b +: 8] = d[8*b +: 8];
        end
      end
    end
    @(negedge clk);
    awvalid2 = 1'b0;
    awaddr2  = '0;
    wvalid2  = 1'b0;
    wdata2   = '0;
    wstrb2   = '0;
    wait_high(SIG_BVALID, 2, "bvalid2");
    check_value("bresp2", 32'(bresp2), 32'(exp_resp));
    repeat (dly) begin
      @(negedge clk);
      #1;
      check_value("bvalid2", 32'(bvalid2), 32'd1);
      check_value("bresp2", 32'(bresp2), 32'(exp_resp));
    end
    @(negedge clk);
    bready2 = 1'b1;
    #1;
    check_value("bvalid2", 32'(bvalid2), 32'd1);
    @(negedge clk);
    bready2 = 1'b0;
  endtask

  initial begin
    int                 fd;
    int                 n;
    string              line;
    logic [15:0]        op;
    mem_bus_pkg::addr_t addr;
    mem_bus_pkg::data_t data;
    mem_bus_pkg::strb_t strb;
    int                 dly1;
    int                 dly2;
    time                t_rv1;
    time                t_hs1;
    time                t_rv2;
    time                t_hs2;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    for (int i = 0; i < mem_bus_pkg::SRAM_WORDS; i++) begin
      shadow[i] = '0;
    end
    rst      = 1'b1;
    arvalid1 = 1'b0;
    araddr1  = '0;
    rready1  = 1'b0;
    arvalid2 = 1'b0;
    araddr2  = '0;
    rready2  = 1'b0;
    awvalid2 = 1'b0;
    awaddr2  = '0;
    wvalid2  = 1'b0;
    wdata2   = '0;
    wstrb2   = '0;
    bready2  = 1'b0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    #1;
    check_value("arready1", 32'(arready1), 32'd0);
    check_value("rvalid1", 32'(rvalid1), 32'd0);
    check_value("arready2", 32'(arready2), 32'd0);
    check_value("rvalid2", 32'(rvalid2), 32'd0);
    check_value("awready2", 32'(awready2), 32'd0);
    check_value("wready2", 32'(wready2), 32'd0);
    check_value("bvalid2", 32'(bvalid2), 32'd0);
    fd = $fopen("tests/mem_subsys_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the stimulus file tests/mem_subsys_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          op   = '0;
          n    = $sscanf(line, "%s %h %h %h", op, addr, data, strb);
          dly1 = random_delay();
          dly2 = random_delay();
          case (op)
            "R1": do_read(1, addr, dly1, t_rv1, t_hs1);
            "R2": do_read(2, addr, dly1, t_rv2, t_hs2);
            "W2": do_write(addr, data, strb, dly1);
            16'("P"): begin
              // data column is client 2's address here
              fork
                do_read(1, addr, dly1, t_rv1, t_hs1);
                do_read(2, data, dly2, t_rv2, t_hs2);
              join
              checks++;
              assert (t_hs1 < t_rv2) else begin
                errors++;
                $display("client 2 saw rvalid at %0t ns before client 1 finished at %0t ns",
                         t_rv2, t_hs1);
              end
            end
            default: begin
              errors++;
              $display("unknown operation in stimulus line: %s", line);
            end
          endcase
        end
      end
      $fclose(fd);
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/mem_bus_pkg.sv
src/mem_arbiter.sv
src/sram_axi_slave.sv
src/mem_subsys_top.sv
tests/mem_arbiter_checker.sv
tests/mem_subsys_tb.sv
